/* logic/cma_pkg.sv */
////////////////////////////////////////
// equalizer output stage shared types
// widths, tap count, saturation limits
// packed structs and the clip function
////////////////////////////////////////

package cma_pkg;

    localparam int data_w     = 18;  // Q1.17 samples, coefficients and products
    localparam int num_taps   = 16;
    localparam int group_taps = 8;   // taps per first-level adder group
    localparam int addr_w     = 4;
    localparam int sum_w      = 21;  // eight 18-bit words need three guard bits

    // symmetric limits, -2^17 is never produced by clipping
    localparam logic signed [data_w-1:0] max_pos = (2 ** (data_w - 1)) - 1;
    localparam logic signed [data_w-1:0] max_neg = -((2 ** (data_w - 1)) - 1);

    typedef struct packed {
        logic                     strobe;
        logic signed [data_w-1:0] value;
    } sample_t;

    typedef struct packed {
        logic                     strobe;
        logic [addr_w-1:0]        addr;
        logic signed [data_w-1:0] data;
    } coef_wr_t;

    // element 0 is tap 0, the newest sample
    typedef logic signed [num_taps-1:0][data_w-1:0] tap_vec_t;

    typedef struct packed {
        logic                     valid;
        logic                     sat;   // set when anything on the path clipped
        logic signed [data_w-1:0] sum;
    } fir_out_t;

    // clips a wide signed value back to data_w bits and reports the event
    function automatic logic signed [data_w-1:0] sat_clip(
        input  logic signed [sum_w-1:0] x,
        output logic                    hit
    );
        hit = (x[sum_w-1:data_w-1] != {(sum_w - data_w + 1){x[sum_w-1]}});
        if (!hit) begin
            return x[data_w-1:0];  // in range, -2^17 included
        end else if (x[sum_w-1]) begin
            return max_neg;
        end else begin
            return max_pos;
        end
    endfunction

endpackage

/* logic/coef_bank.sv */
////////////////////////////////////////
// coefficient store for the equalizer
// sixteen registers, host strobe write
////////////////////////////////////////

`timescale 1ns/1ps

module coef_bank (
    input  logic              CK,
    input  logic              arst_n,
    input  cma_pkg::coef_wr_t coef_wr,
    output cma_pkg::tap_vec_t coefs
);

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    // the taps start at zero so the filter output is silent until the
    // host has loaded at least one coefficient
    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            coefs <= '0;
        end else if (coef_wr.strobe) begin
            coefs[coef_wr.addr] <= coef_wr.data;  // visible to the multipliers next cycle
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // -2^17 has no positive mirror in Q1.17, the multipliers rely on
    // the coefficient range being symmetric
    a_coef_symmetric: assert property (
        @(posedge CK) disable iff (!arst_n)
        coef_wr.strobe |-> (coef_wr.data >= cma_pkg::max_neg)
    );

endmodule

/* logic/tap_multiply.sv */
////////////////////////////////////////
// sample delay line and tap multipliers
// Q1.17 products with floor and clipping
////////////////////////////////////////

`timescale 1ns/1ps

module tap_multiply (
    input  logic              CK,
    input  logic              arst_n,
    input  cma_pkg::sample_t  sample_in,
    input  cma_pkg::tap_vec_t coefs,
    output cma_pkg::tap_vec_t products,
    output logic              prod_valid,
    output logic              prod_sat
);

    cma_pkg::tap_vec_t                   taps;      // delay line, taps[0] is newest
    logic                                strobe_q;  // line shifted on the previous edge
    logic signed [2*cma_pkg::data_w-1:0] full [cma_pkg::num_taps];
    cma_pkg::tap_vec_t                   prod_next;
    logic [cma_pkg::num_taps-1:0]        tap_hit;

    ////////////////////////////////////////
    // delay line
    ////////////////////////////////////////

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            taps     <= '0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= sample_in.strobe;
            if (sample_in.strobe) begin
                taps <= {taps[cma_pkg::num_taps-2:0], sample_in.value};  // oldest drops out
            end
        end
    end

    ////////////////////////////////////////
    // multipliers
    ////////////////////////////////////////

    // the 36-bit product carries 34 fraction bits, an arithmetic shift by
    // 17 floors it back to Q1.17 with one extra integer bit to clip
    always_comb begin
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            full[i]      = $signed(taps[i]) * $signed(coefs[i]);
            prod_next[i] = cma_pkg::sat_clip(
                cma_pkg::sum_w'(full[i] >>> (cma_pkg::data_w - 1)), tap_hit[i]);
        end
    end

    always_ff @(posedge CK) begin
        if (strobe_q) begin
            products <= prod_next;  // held until the next sample
        end
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            prod_sat   <= 1'b0;
        end else begin
            prod_valid <= strobe_q;
            prod_sat   <= strobe_q & (|tap_hit);  // any tap clipped for this sample
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // every product pulse belongs to a strobe two edges earlier
    a_valid_from_strobe: assert property (
        @(posedge CK) disable iff (!arst_n)
        prod_valid |-> $past(sample_in.strobe, 2)
    );

endmodule

/* logic/tap_sum.sv */
////////////////////////////////////////
// two-stage tap summer
// group sums of eight, then the final sum
// clipping and flag at every stage
////////////////////////////////////////

`timescale 1ns/1ps

module tap_sum (
    input  logic               CK,
    input  logic               arst_n,
    input  cma_pkg::tap_vec_t  products,
    input  logic               prod_valid,
    input  logic               prod_sat,
    output cma_pkg::fir_out_t  fir_out
);

    logic signed [cma_pkg::sum_w-1:0]  grp_raw  [2];  // full-precision group sums
    logic signed [cma_pkg::data_w-1:0] grp_clip [2];
    logic [1:0]                        grp_hit;
    logic signed [cma_pkg::data_w-1:0] grp_q    [2];
    logic                              grp_valid;
    logic                              grp_sat;
    logic signed [cma_pkg::data_w:0]   fin_raw;       // one guard bit for two words
    logic signed [cma_pkg::data_w-1:0] fin_clip;
    logic                              fin_hit;
    logic signed [cma_pkg::data_w-1:0] out_sum;
    logic                              out_valid;
    logic                              out_sat;

    ////////////////////////////////////////
    // first level, two groups of eight
    ////////////////////////////////////////

    always_comb begin
        for (int g = 0; g < 2; g++) begin
            grp_raw[g] = '0;
            for (int t = 0; t < cma_pkg::group_taps; t++) begin
                grp_raw[g] += cma_pkg::sum_w'($signed(products[g*cma_pkg::group_taps + t]));
            end
            grp_clip[g] = cma_pkg::sat_clip(grp_raw[g], grp_hit[g]);
        end
    end

    always_ff @(posedge CK) begin
        if (prod_valid) begin
            grp_q[0] <= grp_clip[0];  // taps 0 to 7
            grp_q[1] <= grp_clip[1];  // taps 8 to 15
        end
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            grp_valid <= 1'b0;
            grp_sat   <= 1'b0;
        end else begin
            grp_valid <= prod_valid;
            grp_sat   <= prod_valid & (prod_sat | (|grp_hit));  // flag follows the sample
        end
    end

    ////////////////////////////////////////
    // second level, final sum
    ////////////////////////////////////////

    always_comb begin
        fin_raw  = (cma_pkg::data_w + 1)'(grp_q[0]) + (cma_pkg::data_w + 1)'(grp_q[1]);
        fin_clip = cma_pkg::sat_clip(cma_pkg::sum_w'(fin_raw), fin_hit);
    end

    always_ff @(posedge CK) begin
        if (grp_valid) begin
            out_sum <= fin_clip;
        end
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_sat   <= 1'b0;
        end else begin
            out_valid <= grp_valid;
            out_sat   <= grp_valid & (grp_sat | fin_hit);
        end
    end

    assign fir_out = '{valid: out_valid, sat: out_sat, sum: out_sum};

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a clipped path ends on a symmetric limit, never on -2^17
    a_sat_symmetric: assert property (
        @(posedge CK) disable iff (!arst_n)
        fir_out.sat |-> (fir_out.sum >= cma_pkg::max_neg)
    );

endmodule

/* logic/cma_fir_top.sv */
////////////////////////////////////////
// equalizer output stage top level
// coefficient bank, multipliers, summer
////////////////////////////////////////

`timescale 1ns/1ps

module cma_fir_top (
    input  logic              CK,
    input  logic              arst_n,
    input  cma_pkg::sample_t  sample_in,
    input  cma_pkg::coef_wr_t coef_wr,
    output cma_pkg::fir_out_t fir_out
);

    cma_pkg::tap_vec_t coefs;
    cma_pkg::tap_vec_t products;
    logic              prod_valid;
    logic              prod_sat;

    ////////////////////////////////////////
    // pipeline, four cycles strobe to out
    ////////////////////////////////////////

    coef_bank i_coef_bank (
        .CK      (CK),
        .arst_n  (arst_n),
        .coef_wr (coef_wr),
        .coefs   (coefs)
    );

    // shifts on the strobe edge, products one edge later
    tap_multiply i_tap_multiply (
        .CK         (CK),
        .arst_n     (arst_n),
        .sample_in  (sample_in),
        .coefs      (coefs),
        .products   (products),
        .prod_valid (prod_valid),
        .prod_sat   (prod_sat)
    );

    // group sums and final sum take two more edges
    tap_sum i_tap_sum (
        .CK         (CK),
        .arst_n     (arst_n),
        .products   (products),
        .prod_valid (prod_valid),
        .prod_sat   (prod_sat),
        .fir_out    (fir_out)
    );

endmodule

/* bench/cma_fir_tb.sv */
////////////////////////////////////////
// testbench for the equalizer output stage
// stimulus table, reference model, monitor
////////////////////////////////////////

`timescale 1ns/1ps

module cma_fir_tb;

    typedef enum {op_coef, op_sample} entry_kind_e;

    typedef struct {
        entry_kind_e kind;
        int          addr;
        int          value;
        int          gap;    // idle cycles after the entry
    } entry_t;

    typedef struct {
        int     due;         // cycle in which fir_out.valid must be high
        longint sum;
        logic   sat;
    } exp_t;

    logic              CK;
    logic              arst_n;
    cma_pkg::sample_t  sample_in;
    cma_pkg::coef_wr_t coef_wr;
    cma_pkg::fir_out_t fir_out;

    entry_t table_q[$];
    exp_t   exp_q[$];
    exp_t   popped;
    longint model_coef [cma_pkg::num_taps];
    longint model_line [cma_pkg::num_taps];   // model_line[0] is the newest sample
    int     cycle = 0;
    int     seed  = 32'h8962;

    cma_fir_top i_dut (
        .CK        (CK),
        .arst_n    (arst_n),
        .sample_in (sample_in),
        .coef_wr   (coef_wr),
        .fir_out   (fir_out)
    );

    initial begin
        CK = 1'b0;
        forever #5 CK = ~CK;
    end

    always @(posedge CK) begin
        cycle <= cycle + 1;  // cycle n is the period after the n-th rising edge
    end

    ////////////////////////////////////////
    // error reporting
    ////////////////////////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input longint exp, input longint got);
        stop_with_failure($sformatf("** Error at time %0t: %s expected %0d, got %0d",
                                    $time, name, exp, got));
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic longint clip_to_limits(input longint x, inout logic hit);
        longint lim;
        lim = longint'(cma_pkg::max_pos);
        if (x > lim) begin
            hit = 1'b1;
            return lim;
        end else if (x < -lim - 1) begin
            hit = 1'b1;
            return -lim;  // limits are symmetric
        end
        return x;         // -2^17 is a legal result and is kept
    endfunction

    function automatic void predict_output(input int value, input int due);
        exp_t   e;
        longint grp [2];
        longint prod;
        logic   hit;
        hit    = 1'b0;
        grp[0] = 0;
        grp[1] = 0;
        for (int i = cma_pkg::num_taps - 1; i > 0; i--) begin
            model_line[i] = model_line[i-1];
        end
        model_line[0] = value;
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            prod = (model_line[i] * model_coef[i]) >>> (cma_pkg::data_w - 1);  // floor
            prod = clip_to_limits(prod, hit);
            grp[i / cma_pkg::group_taps] += prod;
        end
        grp[0] = clip_to_limits(grp[0], hit);
        grp[1] = clip_to_limits(grp[1], hit);
        e.sum  = clip_to_limits(grp[0] + grp[1], hit);
        e.sat  = hit;
        e.due  = due;
        exp_q.push_back(e);
    endfunction

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic add_coef_write(input int addr, input int value);
        table_q.push_back('{kind: op_coef, addr: addr, value: value, gap: 0});
    endtask

    task automatic queue_sample(input int value, input int gap);
        table_q.push_back('{kind: op_sample, addr: 0, value: value, gap: gap});
    endtask

    task automatic build_table();
        int v;
        int pos;
        pos = int'(cma_pkg::max_pos);
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            v = (i + 1) * 7001;
            add_coef_write(i, (i % 2) ? -v : v);  // distinct, alternating sign
        end
        queue_sample(pos, 0);                     // impulse walks through the taps
        repeat (15) queue_sample(0, 0);
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            add_coef_write(i, $random(seed) % 4096);
        end
        repeat (24) queue_sample($random(seed) % 131072, 0);
        repeat (24) queue_sample($random(seed) % 131072, {$random(seed)} % 4);
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            add_coef_write(i, (i == 0) ? -pos : 0);
        end
        queue_sample(-131072, 4);                 // exact product lands on max_pos
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            add_coef_write(i, pos - 100);
        end
        repeat (16) queue_sample(pos - 50, 0);    // group sums overflow upwards
        repeat (16) queue_sample(-(pos - 50), 0); // and then downwards
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            add_coef_write(i, (i == 0) ? 2000 : 0);
        end
        queue_sample(50000, 1);
        add_coef_write(0, -3000);                 // only later samples see this
        queue_sample(50000, 0);
        queue_sample(50000, 2);
    endtask

    ////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////

    always @(negedge CK) begin
        if (arst_n) begin
            if (fir_out.valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("fir_out.valid pulsed with no sample in flight");
                end else begin
                    popped = exp_q.pop_front();
                    assert (cycle == popped.due)
                        else report_mismatch("fir_out.valid cycle", popped.due, cycle);
                    assert ($signed(fir_out.sum) == popped.sum)
                        else report_mismatch("fir_out.sum", popped.sum, $signed(fir_out.sum));
                    assert (fir_out.sat == popped.sat)
                        else report_mismatch("fir_out.sat", popped.sat, fir_out.sat);
                end
            end else if (exp_q.size() != 0 && cycle > exp_q[0].due) begin
                stop_with_failure("fir_out.valid did not come four cycles after its strobe");
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        entry_t ent;
        int     wait_cycles;
        arst_n    = 1'b0;
        sample_in = '0;
        coef_wr   = '0;
        for (int i = 0; i < cma_pkg::num_taps; i++) begin
            model_coef[i] = 0;
            model_line[i] = 0;
        end
        build_table();
        repeat (10) @(posedge CK);
        arst_n <= 1'b1;
        repeat (8) begin
            @(negedge CK);
            assert (!fir_out.valid && !fir_out.sat)  // quiet before the first strobe
                else stop_with_failure("fir_out.valid or fir_out.sat rose before any sample");
        end
        for (int n = 0; n < table_q.size(); n++) begin
            ent = table_q[n];
            @(posedge CK);
            if (ent.kind == op_coef) begin
                model_coef[ent.addr] = ent.value;
                coef_wr          <= '{strobe: 1'b1, addr: ent.addr[3:0],
                                      data: cma_pkg::data_w'(ent.value)};
                sample_in.strobe <= 1'b0;
            end else begin
                predict_output(ent.value, cycle + 5);  // strobe is high in cycle + 1
                sample_in      <= '{strobe: 1'b1, value: cma_pkg::data_w'(ent.value)};
                coef_wr.strobe <= 1'b0;
            end
            repeat (ent.gap) begin
                @(posedge CK);
                sample_in.strobe <= 1'b0;
                coef_wr.strobe   <= 1'b0;
            end
        end
        @(posedge CK);
        sample_in.strobe <= 1'b0;
        coef_wr.strobe   <= 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 20) begin
            @(negedge CK);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            stop_with_failure("outputs still pending when the drain wait timed out");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* cma_fir_top.f */
logic/cma_pkg.sv
logic/coef_bank.sv
logic/tap_multiply.sv
logic/tap_sum.sv
logic/cma_fir_top.sv
bench/cma_fir_tb.sv

/* Bender.yml */
package:
  name: cma_fir

sources:
  - logic/cma_pkg.sv
  - logic/coef_bank.sv
  - logic/tap_multiply.sv
  - logic/tap_sum.sv
  - logic/cma_fir_top.sv
  - target: simulation
    files:
      - bench/cma_fir_tb.sv
